/* hdl/mmioPkg.sv */
`default_nettype none

package mmioPkg;

    // ------------------------------------------------------------------------
    // fabric request / response encoding
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        RD     = 2'b00,
        WR     = 2'b01,
        RD_RSP = 2'b10
    } tOpcode;

    typedef logic [31:0] tData;
    typedef logic [31:0] tAddr;   // [31:24] tile, [23:22] region, [19:0] offset

    // region field of the address
    typedef logic [1:0] tRegion;
    localparam tRegion DMemRegion = 2'b01;   // vga frame buffer
    localparam tRegion CrRegion   = 2'b10;   // control registers
    localparam int     RegionMsb  = 23;
    localparam int     RegionLsb  = 22;

    // ------------------------------------------------------------------------
    // control register map, byte offsets
    // ------------------------------------------------------------------------
    typedef logic [19:0] tCrOffset;
    localparam tCrOffset CrSeg7_0  = 20'h00000;
    localparam tCrOffset CrSeg7_1  = 20'h00004;
    localparam tCrOffset CrSeg7_2  = 20'h00008;
    localparam tCrOffset CrSeg7_3  = 20'h0000C;
    localparam tCrOffset CrSeg7_4  = 20'h00010;
    localparam tCrOffset CrSeg7_5  = 20'h00014;
    localparam tCrOffset CrLed     = 20'h00018;
    localparam tCrOffset CrButton0 = 20'h0001C;   // read only
    localparam tCrOffset CrButton1 = 20'h00020;   // read only
    localparam tCrOffset CrSwitch  = 20'h00024;   // read only

    // board side widths
    typedef logic [6:0] tSeg7;     // raw segments, no decoding
    typedef logic [9:0] tLed;
    typedef logic [9:0] tSwitch;
    typedef logic [3:0] tColor;

    // ------------------------------------------------------------------------
    // video geometry
    // ------------------------------------------------------------------------
    typedef logic [9:0] tPixelCoord;
    localparam int FrameWords   = 9600;   // 640x480 at 1 bpp
    localparam int WordsPerLine = 20;     // 32 pixels per word
    typedef logic [13:0] tFrameAddr;

endpackage

`default_nettype wire

/* hdl/mmioFabricPipe.sv */
`timescale 1ns/1ps
`default_nettype none

module mmioFabricPipe (
    input  wire logic            QClk,
    input  wire logic            rstN,
    // fabric request, one-cycle strobe
    input  wire logic            reqValid,
    input  wire mmioPkg::tOpcode reqOpcode,
    input  wire mmioPkg::tAddr   reqAddress,
    input  wire mmioPkg::tData   reqData,
    // read data back from the targets
    input  wire mmioPkg::tData   crRdData,    // combinational, same cycle
    input  wire mmioPkg::tData   vgaRdData,   // already registered
    // decoded strobes towards the targets
    output logic                 crRdEn,
    output logic                 crWrEn,
    output logic                 vgaRdEn,
    output logic                 vgaWrEn,
    output mmioPkg::tAddr        stageAddress,
    output mmioPkg::tData        stageData,
    // fabric response
    output logic                 rspValid,
    output mmioPkg::tOpcode      rspOpcode,
    output mmioPkg::tAddr        rspAddress,
    output mmioPkg::tData        rspData
);
    import mmioPkg::*;

    logic   stageValid;
    tOpcode stageOpcode;
    tRegion stageRegion;

    // flags one stage later, lined up with the read data
    logic crRdEnQ;
    logic crWrEnQ;
    logic vgaRdEnQ;
    logic vgaWrEnQ;
    tData crDataQ;
    tAddr addressQ;

    logic rspAny;
    tData rspDataNext;

    // ------------------------------------------------------------------------
    // sample stage
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= reqValid;
        end
    end

    always_ff @(posedge QClk) begin
        stageOpcode  <= reqOpcode;
        stageAddress <= reqAddress;
        stageData    <= reqData;
    end

    // region decode, tile bits are ignored
    assign stageRegion = stageAddress[RegionMsb:RegionLsb];

    assign crRdEn  = stageValid && (stageOpcode == RD) && (stageRegion == CrRegion);
    assign crWrEn  = stageValid && (stageOpcode == WR) && (stageRegion == CrRegion);
    assign vgaRdEn = stageValid && (stageOpcode == RD) && (stageRegion == DMemRegion);
    assign vgaWrEn = stageValid && (stageOpcode == WR) && (stageRegion == DMemRegion);

    // ------------------------------------------------------------------------
    // access stage, target acts on this edge
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            crRdEnQ  <= 1'b0;
            crWrEnQ  <= 1'b0;
            vgaRdEnQ <= 1'b0;
            vgaWrEnQ <= 1'b0;
        end else begin
            crRdEnQ  <= crRdEn;
            crWrEnQ  <= crWrEn;
            vgaRdEnQ <= vgaRdEn;
            vgaWrEnQ <= vgaWrEn;
        end
    end

    always_ff @(posedge QClk) begin
        crDataQ  <= crRdData;       // cr load captured here
        addressQ <= stageAddress;
    end

    // ------------------------------------------------------------------------
    // response stage
    // ------------------------------------------------------------------------
    assign rspAny      = crRdEnQ || crWrEnQ || vgaRdEnQ || vgaWrEnQ;
    assign rspDataNext = crRdEnQ  ? crDataQ   :
                         vgaRdEnQ ? vgaRdData :
                                    '0;         // writes answer with 0

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            rspValid   <= 1'b0;
            rspOpcode  <= RD;
            rspAddress <= '0;
            rspData    <= '0;
        end else begin
            rspValid   <= rspAny;
            rspOpcode  <= rspAny ? RD_RSP : RD;     // idle bus stays at 0
            rspAddress <= rspAny ? addressQ : '0;
            rspData    <= rspDataNext;
        end
    end

endmodule

`default_nettype wire

/* hdl/mmioCrRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module mmioCrRegs (
    input  wire logic             QClk,
    input  wire logic             rstN,
    input  wire logic             crRdEn,
    input  wire logic             crWrEn,
    input  wire mmioPkg::tAddr    stageAddress,
    input  wire mmioPkg::tData    stageData,
    input  wire logic             button0,
    input  wire logic             button1,
    input  wire mmioPkg::tSwitch  switches,
    output mmioPkg::tData         crRdData,
    output mmioPkg::tSeg7         seg0,
    output mmioPkg::tSeg7         seg1,
    output mmioPkg::tSeg7         seg2,
    output mmioPkg::tSeg7         seg3,
    output mmioPkg::tSeg7         seg4,
    output mmioPkg::tSeg7         seg5,
    output mmioPkg::tLed          led
);
    import mmioPkg::*;

    // read-write registers
    tSeg7 segReg  [6];
    tSeg7 segNext [6];
    tLed  ledReg;
    tLed  ledNext;

    // read-only registers, refreshed every cycle
    logic   button0Q;
    logic   button1Q;
    tSwitch switchQ;

    tCrOffset offset;
    assign offset = stageAddress[19:0];

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------
    always_comb begin
        segNext = segReg;
        ledNext = ledReg;
        if (crWrEn) begin
            case (offset)
                CrSeg7_0: segNext[0] = stageData[6:0];
                CrSeg7_1: segNext[1] = stageData[6:0];
                CrSeg7_2: segNext[2] = stageData[6:0];
                CrSeg7_3: segNext[3] = stageData[6:0];
                CrSeg7_4: segNext[4] = stageData[6:0];
                CrSeg7_5: segNext[5] = stageData[6:0];
                CrLed:    ledNext    = stageData[9:0];
                default:  ;                     // ro or unmapped, dropped
            endcase
        end
    end

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            segReg   <= '{default: '0};
            ledReg   <= '0;
            button0Q <= 1'b0;
            button1Q <= 1'b0;
            switchQ  <= '0;
        end else begin
            segReg   <= segNext;
            ledReg   <= ledNext;
            button0Q <= button0;    // board inputs, sampled each clock
            button1Q <= button1;
            switchQ  <= switches;
        end
    end

    // ------------------------------------------------------------------------
    // read, sees a write from the same stage
    // ------------------------------------------------------------------------
    always_comb begin
        crRdData = '0;
        if (crRdEn) begin
            case (offset)
                CrSeg7_0:  crRdData = {25'b0, segNext[0]};
                CrSeg7_1:  crRdData = {25'b0, segNext[1]};
                CrSeg7_2:  crRdData = {25'b0, segNext[2]};
                CrSeg7_3:  crRdData = {25'b0, segNext[3]};
                CrSeg7_4:  crRdData = {25'b0, segNext[4]};
                CrSeg7_5:  crRdData = {25'b0, segNext[5]};
                CrLed:     crRdData = {22'b0, ledNext};
                CrButton0: crRdData = {31'b0, button0Q};
                CrButton1: crRdData = {31'b0, button1Q};
                CrSwitch:  crRdData = {22'b0, switchQ};
                default:   crRdData = '0;        // unmapped offset
            endcase
        end
    end

    // board pins follow the registers
    assign seg0 = segReg[0];
    assign seg1 = segReg[1];
    assign seg2 = segReg[2];
    assign seg3 = segReg[3];
    assign seg4 = segReg[4];
    assign seg5 = segReg[5];
    assign led  = ledReg;

endmodule

`default_nettype wire

/* hdl/vgaTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module vgaTiming #(
    parameter int HActive = 640,
    parameter int HFront  = 16,
    parameter int HSync   = 96,
    parameter int HBack   = 48,
    parameter int VActive = 480,
    parameter int VFront  = 10,
    parameter int VSync   = 2,
    parameter int VBack   = 33
) (
    input  wire logic            QClk,
    input  wire logic            rstN,
    output logic                 pixelEn,    // every second QClk
    output mmioPkg::tPixelCoord  pixelX,
    output mmioPkg::tPixelCoord  pixelY,
    output logic                 active,
    output logic                 hSyncRaw,   // active low
    output logic                 vSyncRaw    // active low
);
    import mmioPkg::*;

    localparam int HTotal = HActive + HFront + HSync + HBack;   // 800
    localparam int VTotal = VActive + VFront + VSync + VBack;   // 525

    localparam tPixelCoord HLast      = tPixelCoord'(HTotal - 1);
    localparam tPixelCoord VLast      = tPixelCoord'(VTotal - 1);
    localparam tPixelCoord HSyncStart = tPixelCoord'(HActive + HFront);
    localparam tPixelCoord HSyncStop  = tPixelCoord'(HActive + HFront + HSync);
    localparam tPixelCoord VSyncStart = tPixelCoord'(VActive + VFront);
    localparam tPixelCoord VSyncStop  = tPixelCoord'(VActive + VFront + VSync);

    logic lineEnd;
    logic frameEnd;

    // ------------------------------------------------------------------------
    // pixel clock enable and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            pixelEn <= 1'b0;
        end else begin
            pixelEn <= !pixelEn;    // divide by two
        end
    end

    assign lineEnd  = (pixelX == HLast);
    assign frameEnd = (pixelY == VLast);

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            pixelX <= '0;
            pixelY <= '0;
        end else if (pixelEn) begin
            if (lineEnd) begin
                pixelX <= '0;
                pixelY <= frameEnd ? '0 : pixelY + 1'b1;
            end else begin
                pixelX <= pixelX + 1'b1;
            end
        end
    end

    // visible area and sync pulses from the porch boundaries
    assign active   = (pixelX < tPixelCoord'(HActive)) && (pixelY < tPixelCoord'(VActive));
    assign hSyncRaw = !((pixelX >= HSyncStart) && (pixelX < HSyncStop));
    assign vSyncRaw = !((pixelY >= VSyncStart) && (pixelY < VSyncStop));

endmodule

`default_nettype wire

/* hdl/vgaFrameMem.sv */
`timescale 1ns/1ps
`default_nettype none

module vgaFrameMem (
    input  wire logic                QClk,
    input  wire logic                rstN,
    // core port
    input  wire logic                vgaRdEn,
    input  wire logic                vgaWrEn,
    input  wire mmioPkg::tAddr       stageAddress,
    input  wire mmioPkg::tData       stageData,
    // pixel port
    input  wire logic                pixelEn,
    input  wire mmioPkg::tPixelCoord pixelX,
    input  wire mmioPkg::tPixelCoord pixelY,
    input  wire logic                active,
    input  wire logic                hSyncRaw,
    input  wire logic                vSyncRaw,
    output mmioPkg::tData            vgaRdData,
    output mmioPkg::tColor           red,
    output mmioPkg::tColor           green,
    output mmioPkg::tColor           blue,
    output logic                     hSync,
    output logic                     vSync
);
    import mmioPkg::*;

    localparam tColor FullOn = 4'hF;

    tData      frameMem [FrameWords];   // one bit per pixel
    tFrameAddr coreIdx;
    tFrameAddr pixIdx;
    tData      pixWord;
    logic      pixOn;

    // byte offset to word index, wraps past the last word
    assign coreIdx = tFrameAddr'(stageAddress[19:2] % FrameWords);

    // ------------------------------------------------------------------------
    // core access
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk) begin
        if (vgaWrEn) begin
            frameMem[coreIdx] <= stageData;   // full word only
        end
    end

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            vgaRdData <= '0;
        end else begin
            vgaRdData <= vgaRdEn ? frameMem[coreIdx] : '0;
        end
    end

    // ------------------------------------------------------------------------
    // pixel fetch
    // ------------------------------------------------------------------------
    assign pixIdx  = active ? tFrameAddr'(pixelY * WordsPerLine + pixelX[9:5]) : '0;
    assign pixWord = frameMem[pixIdx];
    assign pixOn   = active && pixWord[pixelX[4:0]];

    // colour and syncs leave on the same pixel stage
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else if (pixelEn) begin
            red   <= pixOn ? FullOn : '0;
            green <= pixOn ? FullOn : '0;
            blue  <= pixOn ? FullOn : '0;
            hSync <= hSyncRaw;
            vSync <= vSyncRaw;
        end
    end

endmodule

`default_nettype wire

/* hdl/mmioTop.sv */
`timescale 1ns/1ps
`default_nettype none

module mmioTop #(
    parameter int HActive = 640,
    parameter int HFront  = 16,
    parameter int HSync   = 96,
    parameter int HBack   = 48,
    parameter int VActive = 480,
    parameter int VFront  = 10,
    parameter int VSync   = 2,
    parameter int VBack   = 33
) (
    input  wire logic             QClk,
    input  wire logic             rstN,
    // fabric side
    input  wire logic             reqValid,
    input  wire mmioPkg::tOpcode  reqOpcode,
    input  wire mmioPkg::tAddr    reqAddress,
    input  wire mmioPkg::tData    reqData,
    output logic                  rspValid,
    output mmioPkg::tOpcode       rspOpcode,
    output mmioPkg::tAddr         rspAddress,
    output mmioPkg::tData         rspData,
    // board inputs
    input  wire logic             button0,
    input  wire logic             button1,
    input  wire mmioPkg::tSwitch  switches,
    // board outputs
    output mmioPkg::tSeg7         seg0,
    output mmioPkg::tSeg7         seg1,
    output mmioPkg::tSeg7         seg2,
    output mmioPkg::tSeg7         seg3,
    output mmioPkg::tSeg7         seg4,
    output mmioPkg::tSeg7         seg5,
    output mmioPkg::tLed          led,
    output mmioPkg::tColor        red,
    output mmioPkg::tColor        green,
    output mmioPkg::tColor        blue,
    output logic                  hSync,
    output logic                  vSync
);
    import mmioPkg::*;

    // strobes and stage buses out of the pipe
    logic crRdEn;
    logic crWrEn;
    logic vgaRdEn;
    logic vgaWrEn;
    tAddr stageAddress;
    tData stageData;
    tData crRdData;
    tData vgaRdData;

    // raster
    logic       pixelEn;
    tPixelCoord pixelX;
    tPixelCoord pixelY;
    logic       active;
    logic       hSyncRaw;
    logic       vSyncRaw;

    mmioFabricPipe i_fabricPipe (
        .QClk         (QClk),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .reqOpcode    (reqOpcode),
        .reqAddress   (reqAddress),
        .reqData      (reqData),
        .crRdData     (crRdData),
        .vgaRdData    (vgaRdData),
        .crRdEn       (crRdEn),
        .crWrEn       (crWrEn),
        .vgaRdEn      (vgaRdEn),
        .vgaWrEn      (vgaWrEn),
        .stageAddress (stageAddress),
        .stageData    (stageData),
        .rspValid     (rspValid),
        .rspOpcode    (rspOpcode),
        .rspAddress   (rspAddress),
        .rspData      (rspData)
    );

    mmioCrRegs i_crRegs (
        .QClk         (QClk),
        .rstN         (rstN),
        .crRdEn       (crRdEn),
        .crWrEn       (crWrEn),
        .stageAddress (stageAddress),
        .stageData    (stageData),
        .button0      (button0),
        .button1      (button1),
        .switches     (switches),
        .crRdData     (crRdData),
        .seg0         (seg0),
        .seg1         (seg1),
        .seg2         (seg2),
        .seg3         (seg3),
        .seg4         (seg4),
        .seg5         (seg5),
        .led          (led)
    );

    // ------------------------------------------------------------------------
    // video, pixel rate from QClk / 2
    // ------------------------------------------------------------------------
    vgaTiming #(
        .HActive (HActive),
        .HFront  (HFront),
        .HSync   (HSync),
        .HBack   (HBack),
        .VActive (VActive),
        .VFront  (VFront),
        .VSync   (VSync),
        .VBack   (VBack)
    ) i_vgaTiming (
        .QClk     (QClk),
        .rstN     (rstN),
        .pixelEn  (pixelEn),
        .pixelX   (pixelX),
        .pixelY   (pixelY),
        .active   (active),
        .hSyncRaw (hSyncRaw),
        .vSyncRaw (vSyncRaw)
    );

    vgaFrameMem i_vgaFrameMem (
        .QClk         (QClk),
        .rstN         (rstN),
        .vgaRdEn      (vgaRdEn),
        .vgaWrEn      (vgaWrEn),
        .stageAddress (stageAddress),
        .stageData    (stageData),
        .pixelEn      (pixelEn),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .active       (active),
        .hSyncRaw     (hSyncRaw),
        .vSyncRaw     (vSyncRaw),
        .vgaRdData    (vgaRdData),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hSync        (hSync),
        .vSync        (vSync)
    );

endmodule

`default_nettype wire

/* testbench/tbMmioTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMmioTop;
    import mmioPkg::*;

    localparam int CycleLimit = 12000;   // four video lines plus the request tests
    localparam int LinePeriod = 1600;    // QClk per line, pixel rate is QClk / 2
    localparam int SyncLow    = 192;

    logic    QClk;
    logic    rstN;
    logic    reqValid;
    tOpcode  reqOpcode;
    tAddr    reqAddress;
    tData    reqData;
    logic    button0;
    logic    button1;
    tSwitch  switches;
    logic    rspValid;
    tOpcode  rspOpcode;
    tAddr    rspAddress;
    tData    rspData;
    tSeg7    seg0;
    tSeg7    seg1;
    tSeg7    seg2;
    tSeg7    seg3;
    tSeg7    seg4;
    tSeg7    seg5;
    tLed     led;
    tColor   red;
    tColor   green;
    tColor   blue;
    logic    hSync;
    logic    vSync;

    int      seed = 32'h85b3;
    int      cycleCount = 0;
    int      errorCount = 0;
    int      testErrStart = 0;
    int      testsFailed = 0;

    // expected responses, oldest first
    int      expCycle [$];
    tAddr    expAddr [$];
    tData    expData [$];
    tAddr    expA;
    tData    expD;

    // reference model of the tile state
    tSeg7     segModel [6];
    tLed      ledModel;
    tData     frameModel [FrameWords];
    tCrOffset rwOffset [7];

    tData    wrData;
    tData    oldVal;
    int      c;
    int      r;
    int      p;
    int      t0;
    int      t1;
    int      t2;
    int      wIdx [8];
    tColor   expColor;
    logic    expH;

    mmioTop i_dut (
        .QClk       (QClk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqOpcode  (reqOpcode),
        .reqAddress (reqAddress),
        .reqData    (reqData),
        .rspValid   (rspValid),
        .rspOpcode  (rspOpcode),
        .rspAddress (rspAddress),
        .rspData    (rspData),
        .button0    (button0),
        .button1    (button1),
        .switches   (switches),
        .seg0       (seg0),
        .seg1       (seg1),
        .seg2       (seg2),
        .seg3       (seg3),
        .seg4       (seg4),
        .seg5       (seg5),
        .led        (led),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hSync      (hSync),
        .vSync      (vSync)
    );

    initial begin
        QClk = 1'b0;
        forever #10 QClk = ~QClk;   // 20 ns period
    end

    always @(posedge QClk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s exp 0x%h got 0x%h (cycle %0d)", name, exp, got, cycleCount);
            errorCount++;
        end
    endtask

    // tile bits are random, the tile accepts any of them
    function automatic tAddr makeAddr(input tRegion region, input logic [19:0] offset);
        logic [7:0] tile;
        tile = $random(seed);
        return {tile, region, 2'b00, offset};
    endfunction

    task automatic sendReq(input tOpcode op, input tAddr addr, input tData data);
        @(posedge QClk);
        #2;
        reqValid   = 1'b1;
        reqOpcode  = op;
        reqAddress = addr;
        reqData    = data;
    endtask

    task automatic idleReq();
        @(posedge QClk);
        #2;
        reqValid   = 1'b0;
        reqOpcode  = RD;
        reqAddress = '0;
        reqData    = '0;
    endtask

    // sampled on edge c+1, answered after edge c+3
    task automatic expectRsp(input tAddr addr, input tData data);
        expCycle.push_back(cycleCount + 3);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic waitNegCycle(input int n);
        do @(negedge QClk); while (cycleCount < n);
    endtask

    task automatic drain();
        while (expCycle.size() != 0) @(negedge QClk);
    endtask

    function automatic tData modelValue(input int k);
        if (k < 6) return {25'b0, segModel[k]};
        return {22'b0, ledModel};
    endfunction

    function automatic tData boardValue(input int k);
        case (k)
            0:       return {25'b0, seg0};
            1:       return {25'b0, seg1};
            2:       return {25'b0, seg2};
            3:       return {25'b0, seg3};
            4:       return {25'b0, seg4};
            5:       return {25'b0, seg5};
            default: return {22'b0, led};
        endcase
    endfunction

    function automatic string outName(input int k);
        if (k == 6) return "led";
        return $sformatf("seg%0d", k);
    endfunction

    // rw registers sit at 4*k, k = 0..6
    function automatic tData crModelRead(input tCrOffset offset);
        case (offset)
            CrButton0: return {31'b0, button0};
            CrButton1: return {31'b0, button1};
            CrSwitch:  return {22'b0, switches};
            default: begin
                if (offset <= CrLed && offset[1:0] == 2'b00) return modelValue(offset >> 2);
                return '0;
            end
        endcase
    endfunction

    task automatic crWrite(input tCrOffset offset, input tData data);
        tAddr addr;
        int   k;
        addr = makeAddr(CrRegion, offset);
        k    = offset >> 2;
        sendReq(WR, addr, data);
        if (k < 6) segModel[k] = data[6:0];
        else ledModel = data[9:0];
        expectRsp(addr, '0);
    endtask

    task automatic crRead(input tCrOffset offset);
        tAddr addr;
        addr = makeAddr(CrRegion, offset);
        sendReq(RD, addr, '0);
        expectRsp(addr, crModelRead(offset));
    endtask

    task automatic vgaWrite(input int idx, input tData data);
        tAddr addr;
        addr = makeAddr(DMemRegion, 20'(idx * 4));
        sendReq(WR, addr, data);
        frameModel[idx % FrameWords] = data;    // offsets wrap
        expectRsp(addr, '0);
    endtask

    task automatic vgaRead(input int idx);
        tAddr addr;
        addr = makeAddr(DMemRegion, 20'(idx * 4));
        sendReq(RD, addr, '0);
        expectRsp(addr, frameModel[idx % FrameWords]);
    endtask

    task automatic waitHsync(input logic level, output int at);
        do @(negedge QClk); while (hSync !== level);
        at = cycleCount;
    endtask

    task automatic finishTest(input int num, input string name);
        if (errorCount != testErrStart) testsFailed++;
        $display("check %0d %s: %s, %0d errors", num, name,
                 (errorCount == testErrStart) ? "passed" : "failed",
                 errorCount - testErrStart);
        testErrStart = errorCount;
    endtask

    // ------------------------------------------------------------------------
    // response checker, outputs settled at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge QClk) begin
        if (rstN) begin
            if (expCycle.size() > 0 && expCycle[0] == cycleCount) begin
                expCycle.delete(0);
                expA     = expAddr.pop_front();
                expD     = expData.pop_front();
                checkWord("rspValid", rspValid, 1'b1);
                checkWord("rspOpcode", rspOpcode, RD_RSP);
                checkWord("rspAddress", rspAddress, expA);
                checkWord("rspData", rspData, expD);
            end else begin
                checkWord("rspValid", rspValid, 1'b0);  // nothing due this cycle
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        rstN       = 1'b0;
        reqValid   = 1'b0;
        reqOpcode  = RD;
        reqAddress = '0;
        reqData    = '0;
        button0    = 1'b0;
        button1    = 1'b0;
        switches   = '0;
        for (int k = 0; k < 6; k++) segModel[k] = '0;
        ledModel = '0;
        for (int k = 0; k < FrameWords; k++) frameModel[k] = '0;
        for (int k = 0; k < 7; k++) rwOffset[k] = tCrOffset'(k * 4);
        repeat (8) @(posedge QClk);
        #2;
        rstN = 1'b1;

        // 1. reset state, before the first pixel update
        @(negedge QClk);
        checkWord("rspValid", rspValid, 1'b0);
        checkWord("rspOpcode", rspOpcode, 0);
        checkWord("rspAddress", rspAddress, 0);
        checkWord("rspData", rspData, 0);
        for (int k = 0; k < 7; k++) checkWord(outName(k), boardValue(k), 0);
        checkWord("red", red, 0);
        checkWord("green", green, 0);
        checkWord("blue", blue, 0);
        checkWord("hSync", hSync, 1'b1);
        checkWord("vSync", vSync, 1'b1);
        finishTest(1, "reset values");

        // 2. rw registers reach the pins one edge after sampling
        for (int k = 0; k < 7; k++) begin
            wrData = $random(seed);
            oldVal = modelValue(k);
            crWrite(rwOffset[k], wrData);
            c = cycleCount;
            idleReq();
            waitNegCycle(c + 1);
            checkWord(outName(k), boardValue(k), oldVal);   // not yet
            waitNegCycle(c + 2);
            checkWord(outName(k), boardValue(k), modelValue(k));
        end
        for (int k = 0; k < 7; k++) crRead(rwOffset[k]);
        idleReq();
        drain();
        finishTest(2, "cr write and read");

        // 3. read-only inputs, unmapped offsets
        for (int n = 0; n < 3; n++) begin
            @(posedge QClk);
            #2;
            button0  = $random(seed);
            button1  = $random(seed);
            switches = $random(seed);
            repeat (2) @(posedge QClk);
            crRead(CrButton0);
            crRead(CrButton1);
            crRead(CrSwitch);
            crRead(20'h00028);
            crRead(20'h00400);
            idleReq();
            drain();
        end
        finishTest(3, "buttons and switches");

        // 4. write burst then read burst, last index past the end
        for (int k = 0; k < 7; k++) wIdx[k] = $unsigned($random(seed)) % FrameWords;
        wIdx[7] = FrameWords + 5;
        for (int k = 0; k < 8; k++) vgaWrite(wIdx[k], $random(seed));
        for (int k = 0; k < 8; k++) vgaRead(wIdx[k]);
        idleReq();
        drain();
        finishTest(4, "frame buffer burst");

        // 5. regions 00 and 11 are ignored
        sendReq(WR, makeAddr(2'b00, CrSeg7_0), ~modelValue(0));
        sendReq(WR, makeAddr(2'b11, CrLed), ~modelValue(6));
        sendReq(RD, makeAddr(2'b00, CrSwitch), '0);
        sendReq(WR, makeAddr(2'b11, 20'(wIdx[0] * 4)), ~frameModel[wIdx[0]]);
        sendReq(WR, makeAddr(2'b00, 20'(wIdx[0] * 4)), ~frameModel[wIdx[0]]);
        idleReq();
        repeat (4) @(negedge QClk);
        for (int k = 0; k < 7; k++) checkWord(outName(k), boardValue(k), modelValue(k));
        for (int k = 0; k < 7; k++) crRead(rwOffset[k]);
        vgaRead(wIdx[0]);
        idleReq();
        drain();
        finishTest(5, "unmapped regions");

        // 6. video, raster restarted so line 0 follows
        vgaWrite(0, 32'hFFFF_FFFF);
        vgaWrite(1, 32'h0000_0000);
        idleReq();
        drain();
        @(posedge QClk);
        #2;
        rstN = 1'b0;
        repeat (8) @(posedge QClk);
        #2;
        rstN = 1'b1;
        r = cycleCount;
        for (int k = 0; k < 6; k++) segModel[k] = '0;
        ledModel = '0;
        // pixel p shows at cycles r+2+2p and r+3+2p
        for (int cyc = r + 2; cyc < r + 2 + 2 * 800; cyc++) begin
            waitNegCycle(cyc);
            p        = (cyc - r - 2) / 2;
            expColor = (p < 32) ? 4'hF : 4'h0;
            expH     = !(p >= 656 && p < 752);
            if (p < 64 || p >= 640) begin   // words 0, 1 and blanking
                checkWord("red", red, expColor);
                checkWord("green", green, expColor);
                checkWord("blue", blue, expColor);
            end
            checkWord("hSync", hSync, expH);
            checkWord("vSync", vSync, 1'b1);
        end
        waitHsync(1'b0, t0);
        waitHsync(1'b1, t1);
        waitHsync(1'b0, t2);
        checkWord("hSync low cycles", t1 - t0, SyncLow);
        checkWord("hSync period cycles", t2 - t0, LinePeriod);
        finishTest(6, "vga timing and pixels");

        $display("6 checks run, %0d failed, %0d errors", testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/mmioPkg.sv
hdl/mmioFabricPipe.sv
hdl/mmioCrRegs.sv
hdl/vgaTiming.sv
hdl/vgaFrameMem.sv
hdl/mmioTop.sv
testbench/tbMmioTop.sv

/* Bender.yml */
package:
  name: mmio_tile

sources:
  - hdl/mmioPkg.sv
  - hdl/mmioFabricPipe.sv
  - hdl/mmioCrRegs.sv
  - hdl/vgaTiming.sv
  - hdl/vgaFrameMem.sv
  - hdl/mmioTop.sv
  - target: test
    files:
      - testbench/tbMmioTop.sv
